// ==== Makefile ====
TOOL       = verilator
TOP        = engine_tb
RTL_TOP    = engine_top
FILELIST   = engine.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== engine.f ====
+incdir+rtl
rtl/engine_pkg.sv
rtl/engine_ifs.sv
rtl/engine_ctrl.sv
rtl/stream_deser.sv
rtl/mac_array.sv
rtl/channel_accum.sv
rtl/result_writeback.sv
rtl/engine_top.sv
verif/engine_tb.sv

// ==== rtl/channel_accum.sv ====
`timescale 1ns/1ps
`include "engine_consts.svh"

module channel_accum import engine_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	lane_if.dst   li,
	input  lane_t i_para,
	input  addr_t i_res_addr,
	wb_if.src     wo
);

	elem_t     psum_mem [`ENG_MAX_SIDE];  // Partial sum per output pixel
	lane_vec_t prod_q;
	side_t     pix_q;
	logic      last_q;
	addr_t     addr_q;
	elem_t     acc;                       // Running sum
	lane_t     idx;                       // Lane being added
	logic      busy;
	logic      fin;                       // Adding the last lane
	logic      done;
	elem_t     sum_nxt;

	assign sum_nxt = acc + prod_q[idx[`ENG_LANE_BITS-1:0]];   // Wraps at 16 bits
	assign fin     = busy && (idx + lane_t'(1) == i_para);
	assign done    = fin && !(last_q && wo.busy);   // Final result waits for the port
	assign li.ready = !busy && !li.valid;
	assign wo.addr  = addr_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
			wo.valid <= 1'b0;
		end else begin
			wo.valid <= 1'b0;
			if (li.valid) begin
				busy <= 1'b1;
				idx <= '0;
			end else if (done) begin
				busy <= 1'b0;
				wo.valid <= last_q;           // Only the last group is written out
			end else if (busy && !fin) begin
				idx <= idx + lane_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (li.valid) begin
			prod_q <= li.prod;
			pix_q <= li.pix;
			last_q <= li.last_grp;
			addr_q <= i_res_addr;
			// Start from zero or from the previous groups
			acc <= li.first_grp ? '0 : psum_mem[li.pix[`ENG_SIDE_BITS-1:0]];
		end else if (busy && !fin) begin
			acc <= sum_nxt;
		end
		if (done) begin
			psum_mem[pix_q[`ENG_SIDE_BITS-1:0]] <= sum_nxt;
			wo.data <= sum_nxt;
		end
	end

endmodule

// ==== rtl/engine_consts.svh ====
`ifndef ENGINE_CONSTS_SVH
`define ENGINE_CONSTS_SVH

// Multiplier lanes, also the widest channel group
`define ENG_LANES      16
`define ENG_LANE_BITS  4      // Index width for one lane

// Partial-sum buffer depth, one entry per output pixel
`define ENG_MAX_SIDE   128
`define ENG_SIDE_BITS  7      // Index width for the buffer

`endif

// ==== rtl/engine_ctrl.sv ====
`timescale 1ns/1ps
`include "engine_consts.svh"

module engine_ctrl import engine_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_start,
	input  chan_t i_i_channel,
	input  chan_t i_o_channel,
	input  side_t i_o_side,
	input  addr_t i_data_start,
	input  addr_t i_weight_start,
	input  addr_t i_result_start,
	input  logic  i_data_full,
	input  logic  i_wgt_full,
	input  logic  i_lane_ready,
	input  logic  i_wb_idle,
	output logic  o_data_load,
	output logic  o_wgt_load,
	output logic  o_p2_reads_en,
	output logic  o_p3_reads_en,
	output addr_t o_p2_addr,
	output addr_t o_p3_addr,
	output lane_t o_para,
	output logic  o_latch,
	output side_t o_pix,
	output logic  o_first_grp,
	output logic  o_last_grp,
	output addr_t o_res_addr,
	output logic  o_done
);

	eng_state_t state;
	chan_t oc_cnt;          // Output channel in progress
	chan_t grp_base;        // First input channel of the group
	side_t pix_rd;          // Next pixel to fetch
	side_t pix_lat;         // Next pixel to hand to the lanes
	addr_t data_ptr;        // Next pixel read address
	addr_t wgt_row;         // Weight row of the output channel
	addr_t res_row;         // Result row of the output channel
	logic  wgt_pend, wgt_ok;
	logic  data_pend, data_rdy;
	logic  rd_done;         // All pixels of the group fetched
	logic  drain;           // Waiting for the last writes
	logic  grp_end, last_oc;
	chan_t nxt_grp;
	addr_t nxt_wrow;
	logic  p2_open;         // A p2 burst is still on its way back

	assign o_last_grp  = (grp_base + chan_t'(o_para)) >= i_i_channel;
	assign o_first_grp = (grp_base == '0);
	assign grp_end  = (pix_lat == i_o_side - side_t'(1));
	assign last_oc  = (oc_cnt == i_o_channel - chan_t'(1));
	assign nxt_grp  = o_last_grp ? '0 : grp_base + chan_t'(o_para);
	assign nxt_wrow = o_last_grp ? wgt_row + addr_t'(i_i_channel) : wgt_row;

	assign o_latch     = (state == st_busy) && data_rdy && i_lane_ready;
	assign o_pix       = pix_lat;
	assign o_res_addr  = res_row + addr_t'(pix_lat);
	assign o_data_load = o_p2_reads_en;   // Deserializer restarts with each request
	assign o_wgt_load  = o_p3_reads_en;
	assign o_done      = (state == st_finish);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			o_para <= '0;
			oc_cnt <= '0;
			grp_base <= '0;
			pix_rd <= '0;
			pix_lat <= '0;
			data_ptr <= '0;
			wgt_row <= '0;
			res_row <= '0;
			{wgt_pend, wgt_ok, data_pend, data_rdy, rd_done, drain} <= '0;
			o_p2_reads_en <= 1'b0;
			o_p3_reads_en <= 1'b0;
			o_p2_addr <= '0;
			o_p3_addr <= '0;
		end else begin
			o_p2_reads_en <= 1'b0;   // Requests are single pulses
			o_p3_reads_en <= 1'b0;
			case (state)
				st_idle: begin
					if (i_start) begin
						state <= st_busy;
						o_para <= (i_i_channel > chan_t'(`ENG_LANES)) ? lane_t'(`ENG_LANES)
						                                            : lane_t'(i_i_channel);
						oc_cnt <= '0;
						grp_base <= '0;
						pix_rd <= '0;
						pix_lat <= '0;
						data_ptr <= i_data_start;
						wgt_row <= i_weight_start;
						res_row <= i_result_start;
						o_p3_reads_en <= 1'b1;          // First weight group right away
						o_p3_addr <= i_weight_start;
						wgt_pend <= 1'b1;
					end
				end
				st_busy: begin
					if (i_wgt_full) begin
						wgt_pend <= 1'b0;
						wgt_ok <= 1'b1;
					end
					if (i_data_full) begin
						data_pend <= 1'b0;
						data_rdy <= 1'b1;
					end
					// Fetch the next pixel once the buffer is free or being latched
					if (wgt_ok && !data_pend && !rd_done && (!data_rdy || o_latch)) begin
						o_p2_reads_en <= 1'b1;
						o_p2_addr <= data_ptr;
						data_pend <= 1'b1;
						data_ptr <= data_ptr + addr_t'(i_i_channel);
						pix_rd <= pix_rd + side_t'(1);
						if (pix_rd == i_o_side - side_t'(1))
							rd_done <= 1'b1;
					end
					if (o_latch) begin
						data_rdy <= 1'b0;
						if (grp_end) begin
							pix_lat <= '0;
							pix_rd <= '0;
							rd_done <= 1'b0;
							wgt_ok <= 1'b0;         // Weights of the next group needed
							if (o_last_grp && last_oc) begin
								drain <= 1'b1;
							end else begin
								grp_base <= nxt_grp;
								wgt_row <= nxt_wrow;
								if (o_last_grp) begin
									oc_cnt <= oc_cnt + chan_t'(1);
									res_row <= res_row + addr_t'(i_o_side);
								end
								data_ptr <= i_data_start + addr_t'(nxt_grp);
								o_p3_reads_en <= 1'b1;
								o_p3_addr <= nxt_wrow + addr_t'(nxt_grp);
								wgt_pend <= 1'b1;
							end
						end else begin
							pix_lat <= pix_lat + side_t'(1);
						end
					end
					if (drain && i_lane_ready && i_wb_idle)
						state <= st_finish;         // Last result has left the port
				end
				st_finish: ;                        // Held until reset
				default: state <= st_idle;
			endcase
		end
	end

	// Burst on p2 seen from the request pulse to the full strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			p2_open <= 1'b0;
		else if (o_p2_reads_en)
			p2_open <= 1'b1;
		else if (i_data_full)
			p2_open <= 1'b0;
	end

	// A port only gets a new request after its previous burst is complete
	assert property (@(posedge clk) disable iff (rst) o_p2_reads_en |-> !p2_open);
	assert property (@(posedge clk) disable iff (rst) o_p3_reads_en |-> !$past(wgt_pend));

endmodule

// ==== rtl/engine_ifs.sv ====
`timescale 1ns/1ps

// Lane products from the multipliers to the reducer
interface lane_if import engine_pkg::*; ();
	lane_vec_t prod;        // Low halves of the products
	logic      valid;       // One cycle per pixel
	side_t     pix;         // Pixel the products belong to
	logic      first_grp;   // Start the sum from zero
	logic      last_grp;    // Sum is final, send it out
	logic      ready;       // Reducer can take a new pixel

	modport src (output prod, valid, pix, first_grp, last_grp, input ready);
	modport dst (input prod, valid, pix, first_grp, last_grp, output ready);
endinterface

// Finished results from the reducer to the write port
interface wb_if import engine_pkg::*; ();
	elem_t data;
	addr_t addr;
	logic  valid;           // One cycle per result
	logic  busy;            // Write port still holds a result

	modport src (output data, addr, valid, input busy);
	modport dst (input data, addr, valid, output busy);
endinterface

// ==== rtl/engine_pkg.sv ====
`include "engine_consts.svh"

package engine_pkg;

	typedef logic [15:0] elem_t;       // Data, weight or result word
	typedef logic [29:0] addr_t;       // DMA word address
	typedef logic [15:0] chan_t;       // Channel count or index
	typedef logic [7:0]  side_t;       // Pixel count or index
	typedef logic [4:0]  lane_t;       // Lane count up to 16

	// One word per lane
	typedef elem_t [`ENG_LANES-1:0] lane_vec_t;

	// Job state machine
	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_finish
	} eng_state_t;

endpackage

// ==== rtl/engine_top.sv ====
`timescale 1ns/1ps

module engine_top import engine_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_start,
	input  chan_t i_i_channel,
	input  chan_t i_o_channel,
	input  side_t i_o_side,
	input  addr_t i_data_start,
	input  addr_t i_weight_start,
	input  addr_t i_result_start,
	input  elem_t i_p2_ob_data,
	input  logic  i_p2_ob_we,
	input  elem_t i_p3_ob_data,
	input  logic  i_p3_ob_we,
	input  logic  i_p0_ib_re,
	output logic  o_p2_reads_en,
	output addr_t o_p2_addr,
	output logic  o_p3_reads_en,
	output addr_t o_p3_addr,
	output logic  o_p0_writes_en,
	output addr_t o_p0_addr,
	output elem_t o_p0_ib_data,
	output logic  o_p0_ib_valid,
	output logic  o_done
);

	lane_if    lane_bus ();
	wb_if      wb_bus ();
	lane_t     para;
	logic      data_load, wgt_load;
	logic      data_full, wgt_full;
	lane_vec_t data_buf, wgt_buf;
	logic      latch, first_grp, last_grp;
	side_t     pix;
	addr_t     ctrl_res_addr, mac_res_addr;

	engine_ctrl u_ctrl (
		.clk(clk), .rst(rst), .i_start(i_start),
		.i_i_channel(i_i_channel), .i_o_channel(i_o_channel), .i_o_side(i_o_side),
		.i_data_start(i_data_start), .i_weight_start(i_weight_start),
		.i_result_start(i_result_start),
		.i_data_full(data_full), .i_wgt_full(wgt_full),
		.i_lane_ready(lane_bus.ready), .i_wb_idle(~wb_bus.busy),
		.o_data_load(data_load), .o_wgt_load(wgt_load),
		.o_p2_reads_en(o_p2_reads_en), .o_p3_reads_en(o_p3_reads_en),
		.o_p2_addr(o_p2_addr), .o_p3_addr(o_p3_addr), .o_para(para),
		.o_latch(latch), .o_pix(pix), .o_first_grp(first_grp), .o_last_grp(last_grp),
		.o_res_addr(ctrl_res_addr), .o_done(o_done)
	);

	stream_deser data_deser (
		.clk(clk), .rst(rst), .i_load(data_load), .i_para(para),
		.i_we(i_p2_ob_we), .i_word(i_p2_ob_data), .o_full(data_full), .o_buf(data_buf)
	);

	stream_deser wgt_deser (
		.clk(clk), .rst(rst), .i_load(wgt_load), .i_para(para),
		.i_we(i_p3_ob_we), .i_word(i_p3_ob_data), .o_full(wgt_full), .o_buf(wgt_buf)
	);

	mac_array u_mac (
		.clk(clk), .rst(rst), .i_latch(latch), .i_data(data_buf), .i_wgt(wgt_buf),
		.i_pix(pix), .i_first_grp(first_grp), .i_last_grp(last_grp),
		.i_res_addr(ctrl_res_addr), .lo(lane_bus.src), .o_res_addr(mac_res_addr)
	);

	channel_accum u_accum (
		.clk(clk), .rst(rst), .li(lane_bus.dst), .i_para(para),
		.i_res_addr(mac_res_addr), .wo(wb_bus.src)
	);

	result_writeback u_wb (
		.clk(clk), .rst(rst), .wi(wb_bus.dst), .i_ib_re(i_p0_ib_re),
		.o_writes_en(o_p0_writes_en), .o_addr(o_p0_addr),
		.o_ib_data(o_p0_ib_data), .o_ib_valid(o_p0_ib_valid)
	);

endmodule

// ==== rtl/mac_array.sv ====
`timescale 1ns/1ps
`include "engine_consts.svh"

module mac_array import engine_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      i_latch,
	input  lane_vec_t i_data,
	input  lane_vec_t i_wgt,
	input  side_t     i_pix,
	input  logic      i_first_grp,
	input  logic      i_last_grp,
	input  addr_t     i_res_addr,
	lane_if.src       lo,
	output addr_t     o_res_addr
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lo.valid <= 1'b0;
		else
			lo.valid <= i_latch;            // Products ready next cycle
	end

	always_ff @(posedge clk) begin
		if (i_latch) begin
			for (int i = 0; i < `ENG_LANES; i++)
				lo.prod[i] <= i_data[i] * i_wgt[i];   // Low 16 bits kept
			lo.pix <= i_pix;
			lo.first_grp <= i_first_grp;
			lo.last_grp <= i_last_grp;
			o_res_addr <= i_res_addr;       // Travels with the pixel
		end
	end

endmodule

// ==== rtl/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback import engine_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	wb_if.dst     wi,
	input  logic  i_ib_re,
	output logic  o_writes_en,
	output addr_t o_addr,
	output elem_t o_ib_data,
	output logic  o_ib_valid
);

	assign wi.busy = wi.valid | o_writes_en;   // Covers the cycle before writes_en rises

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_writes_en <= 1'b0;
			o_ib_valid <= 1'b0;
		end else begin
			o_ib_valid <= o_writes_en && i_ib_re;   // One cycle after the accept
			if (wi.valid)
				o_writes_en <= 1'b1;
			else if (i_ib_re)
				o_writes_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wi.valid) begin
			o_addr <= wi.addr;
			o_ib_data <= wi.data;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		o_writes_en |=> !o_writes_en || ($stable(o_addr) && $stable(o_ib_data)));

endmodule

// ==== rtl/stream_deser.sv ====
`timescale 1ns/1ps
`include "engine_consts.svh"

module stream_deser import engine_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      i_load,
	input  lane_t     i_para,
	input  logic      i_we,
	input  elem_t     i_word,
	output logic      o_full,
	output lane_vec_t o_buf
);

	lane_vec_t words_q;     // Collected burst
	lane_t     cnt;         // Words received so far
	logic      active;      // Burst still expected

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			active <= 1'b0;
			o_full <= 1'b0;
		end else begin
			o_full <= 1'b0;
			if (i_load) begin
				cnt <= '0;
				active <= 1'b1;
			end else if (i_we && active) begin
				cnt <= cnt + lane_t'(1);
				if (cnt + lane_t'(1) == i_para) begin
					active <= 1'b0;
					o_full <= 1'b1;       // Cycle after the last word
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_we && active)
			words_q[cnt[`ENG_LANE_BITS-1:0]] <= i_word;
	end

	// Unused lanes read as zero
	always_comb begin
		for (int i = 0; i < `ENG_LANES; i++)
			o_buf[i] = (lane_t'(i) < i_para) ? words_q[i] : '0;
	end

	assert property (@(posedge clk) disable iff (rst) i_we |-> active);

endmodule

// ==== verif/engine_patterns.txt ====
// Job count, then per job: i_channel o_channel o_side data_start weight_start result_start,
// data words, weight words, expected results by output channel then pixel (all hex)
2
// Job 1, one group of 4 channels, last pixel has a product above 16 bits
4 2 3 100 200 300
0001 0002 0003 0004
0005 0006 0007 0008
0010 0020 0030 8000
0001 0001 0001 0001
0001 0002 0003 0004
000a 001a 8060 001e 0046 00e0
// Job 2, two groups of 16 channels, pixel 0 wraps its sum
20 1 2 400 500 600
0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900
0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900
0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
0011 0012 0013 0014 0015 0016 0017 0018 0019 001a 001b 001c 001d 001e 001f 0020
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
4000 0520

// ==== verif/engine_tb.sv ====
`timescale 1ns/1ps
`include "engine_consts.svh"

module engine_tb import engine_pkg::*; ();

	logic  clk;
	logic  rst;
	logic  start;
	chan_t i_channel, o_channel;
	side_t o_side;
	addr_t data_start, weight_start, result_start;
	elem_t p2_ob_data = '0;         // Driven by the DMA model
	logic  p2_ob_we = 1'b0;
	elem_t p3_ob_data = '0;
	logic  p3_ob_we = 1'b0;
	logic  p0_ib_re = 1'b0;
	logic  o_p2_reads_en, o_p3_reads_en, o_p0_writes_en, o_p0_ib_valid, o_done;
	addr_t o_p2_addr, o_p3_addr, o_p0_addr;
	elem_t o_p0_ib_data;

	logic [31:0] pat [0:255];       // Image of the patterns file
	elem_t       mem [0:4095];      // DMA memory
	int          pos;               // Next patterns word
	integer      seed = 32'hb4f1_4f78;
	int          para;
	int          wd_cycles = 0;
	int          n_checks = 0;
	int          n_value_err = 0;
	int          n_proto_err = 0;
	addr_t       exp_p2[$], exp_p3[$], exp_wr_addr[$];
	elem_t       exp_wr_data[$];

	// Read ports with index 0 for p2 and 1 for p3
	int    rd_left [2] = '{0, 0};   // Words still owed
	int    rd_gap [2] = '{0, 0};
	addr_t rd_ptr [2];
	logic  rd_prev [2] = '{1'b0, 1'b0};

	// Write port
	int    wr_wait = 0;             // Cycles until ib_re
	logic  wr_seen = 1'b0;          // Current write already checked
	logic  re_prev = 1'b0;
	addr_t wr_addr;
	elem_t wr_data;
	int    n_writes = 0;
	int    n_valid = 0;

	engine_top uut (
		.clk(clk), .rst(rst), .i_start(start),
		.i_i_channel(i_channel), .i_o_channel(o_channel), .i_o_side(o_side),
		.i_data_start(data_start), .i_weight_start(weight_start),
		.i_result_start(result_start),
		.i_p2_ob_data(p2_ob_data), .i_p2_ob_we(p2_ob_we),
		.i_p3_ob_data(p3_ob_data), .i_p3_ob_we(p3_ob_we), .i_p0_ib_re(p0_ib_re),
		.o_p2_reads_en(o_p2_reads_en), .o_p2_addr(o_p2_addr),
		.o_p3_reads_en(o_p3_reads_en), .o_p3_addr(o_p3_addr),
		.o_p0_writes_en(o_p0_writes_en), .o_p0_addr(o_p0_addr),
		.o_p0_ib_data(o_p0_ib_data), .o_p0_ib_valid(o_p0_ib_valid), .o_done(o_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	task automatic check_word(input string name, input elem_t got, input elem_t exp);
		n_checks++;
		if (got !== exp) begin
			n_value_err++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_value_err++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic protocol_error(input string msg);
		n_proto_err++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	// One cycle of a DMA read port
	task automatic serve_read(input int port, input logic en, input addr_t addr,
	                          output logic we, output elem_t word);
		string pname;
		pname = (port == 0) ? "p2" : "p3";
		we = 1'b0;
		word = '0;
		if (en === 1'b1) begin
			if (rd_prev[port])
				protocol_error({pname, " reads_en is high for more than one cycle"});
			if (rd_left[port] != 0)
				protocol_error({pname, " request before the previous burst was returned"});
			if (addr >= addr_t'(4096))
				protocol_error({pname, " request outside the memory model"});
			if (port == 0 && exp_p2.size() != 0)
				check_addr("o_p2_addr", addr, exp_p2.pop_front());
			else if (port == 1 && exp_p3.size() != 0)
				check_addr("o_p3_addr", addr, exp_p3.pop_front());
			else
				protocol_error({pname, " request beyond the expected ones"});
			rd_left[port] = para;
			rd_ptr[port] = addr;
			rd_gap[port] = rand_below(4);
		end else if (rd_left[port] > 0) begin
			if (rd_gap[port] > 0) begin
				rd_gap[port]--;                 // Idle cycle inside the burst
			end else begin
				we = 1'b1;
				word = mem[rd_ptr[port][11:0]];
				rd_ptr[port] = rd_ptr[port] + addr_t'(1);
				rd_left[port]--;
				rd_gap[port] = rand_below(4);
			end
		end
		rd_prev[port] = (en === 1'b1);
	endtask

	// One cycle of the p0 write port with ib_re after a random delay
	task automatic serve_write();
		if (o_p0_ib_valid !== re_prev)
			protocol_error(re_prev ? "ib_valid missing one cycle after ib_re"
			                       : "ib_valid without a preceding ib_re");
		if (o_p0_ib_valid === 1'b1)
			n_valid++;
		p0_ib_re = 1'b0;
		if (re_prev) begin
			if (o_p0_writes_en !== 1'b0)
				protocol_error("writes_en still high in the cycle after ib_re");
		end else if (o_p0_writes_en === 1'b1) begin
			if (!wr_seen) begin
				wr_seen = 1'b1;
				n_writes++;
				wr_addr = o_p0_addr;
				wr_data = o_p0_ib_data;
				wr_wait = rand_below(5);
				if (exp_wr_addr.size() == 0) begin
					protocol_error("write beyond the expected results");
				end else begin
					check_addr("o_p0_addr", o_p0_addr, exp_wr_addr.pop_front());
					check_word("o_p0_ib_data", o_p0_ib_data, exp_wr_data.pop_front());
				end
			end else begin
				check_addr("o_p0_addr (held)", o_p0_addr, wr_addr);   // Must not move before ib_re
				check_word("o_p0_ib_data (held)", o_p0_ib_data, wr_data);
			end
			if (wr_wait == 0) begin
				p0_ib_re = 1'b1;
				wr_seen = 1'b0;
			end else begin
				wr_wait--;
			end
		end
		re_prev = p0_ib_re;
	endtask

	// DMA model steps on the falling edge
	always @(negedge clk) begin
		serve_read(0, o_p2_reads_en, o_p2_addr, p2_ob_we, p2_ob_data);
		serve_read(1, o_p3_reads_en, o_p3_addr, p3_ob_we, p3_ob_data);
		serve_write();
	end

	task automatic run_job();
		int ic, oc, side, ngrp, nres, base_wr, base_valid;
		addr_t ds, ws, rs;
		ic = int'(pat[pos]);
		oc = int'(pat[pos+1]);
		side = int'(pat[pos+2]);
		ds = addr_t'(pat[pos+3]);
		ws = addr_t'(pat[pos+4]);
		rs = addr_t'(pat[pos+5]);
		pos += 6;
		for (int k = 0; k < ic * side; k++)
			mem[int'(ds) + k] = pat[pos+k][15:0];
		pos += ic * side;
		for (int k = 0; k < ic * oc; k++)
			mem[int'(ws) + k] = pat[pos+k][15:0];
		pos += ic * oc;
		nres = oc * side;
		for (int k = 0; k < nres; k++)
			exp_wr_data.push_back(pat[pos+k][15:0]);
		pos += nres;
		// Request order is output channel, group, then pixel
		para = (ic < `ENG_LANES) ? ic : `ENG_LANES;
		ngrp = ic / para;
		for (int o = 0; o < oc; o++) begin
			for (int g = 0; g < ngrp; g++) begin
				exp_p3.push_back(ws + addr_t'(o * ic + g * para));
				for (int x = 0; x < side; x++)
					exp_p2.push_back(ds + addr_t'(x * ic + g * para));
			end
			for (int x = 0; x < side; x++)
				exp_wr_addr.push_back(rs + addr_t'(o * side + x));
		end
		$display("Job with i_channel %0d, o_channel %0d, o_side %0d", ic, oc, side);
		i_channel = chan_t'(ic);
		o_channel = chan_t'(oc);
		o_side = side_t'(side);
		data_start = ds;
		weight_start = ws;
		result_start = rs;
		rst = 1'b1;                             // o_done only clears here
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (o_done !== 1'b0)
			protocol_error("o_done is not low after reset");
		if ({o_p2_reads_en, o_p3_reads_en, o_p0_writes_en, o_p0_ib_valid} !== 4'b0)
			protocol_error("a DMA strobe is active after reset");
		base_wr = n_writes;
		base_valid = n_valid;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (o_p3_reads_en !== 1'b1)
			protocol_error("no weight request one cycle after i_start");
		while (o_done !== 1'b1)
			@(negedge clk);
		if (n_valid - base_valid != nres)
			protocol_error($sformatf("o_done rose after %0d of %0d writes",
			                         n_valid - base_valid, nres));
		repeat (4) begin
			@(negedge clk);
			if (o_done !== 1'b1)
				protocol_error("o_done dropped before reset");
		end
		if (n_writes - base_wr != nres)
			protocol_error("the number of writes differs from o_channel times o_side");
		if (exp_p2.size() != 0 || exp_p3.size() != 0)
			protocol_error("some expected read requests never came");
	endtask

	initial begin
		int n_jobs, total, p, job_res;
		rst = 1'b1;
		start = 1'b0;
		i_channel = '0;
		o_channel = '0;
		o_side = '0;
		data_start = '0;
		weight_start = '0;
		result_start = '0;
		for (int a = 0; a < 4096; a++)
			mem[a] = elem_t'(a) ^ 16'h5a3c;     // Unloaded words follow their address
		$readmemh("verif/engine_patterns.txt", pat);
		n_jobs = int'(pat[0]);
		total = 0;
		p = 1;
		for (int j = 0; j < n_jobs; j++) begin
			job_res = int'(pat[p+1]) * int'(pat[p+2]);
			total += job_res;
			p += 6 + int'(pat[p]) * (int'(pat[p+2]) + int'(pat[p+1])) + job_res;
		end
		wd_cycles = 200 * total + 1000;
		pos = 1;
		@(negedge clk);
		for (int j = 0; j < n_jobs; j++)
			run_job();
		$display("Checks %0d, value errors %0d, protocol errors %0d",
		         n_checks, n_value_err, n_proto_err);
		if (n_value_err == 0 && n_proto_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the engine never finished", wd_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule
